// File: all.f
source/conv_pkg.sv
source/conv_ctrl.sv
source/image_store.sv
source/kernel_store.sv
source/mac_stage.sv
source/conv_top.sv
testbench/conv_checker.sv
testbench/tb_conv.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_conv -f all.f &&
./obj_dir/Vtb_conv | tee /dev/stderr | grep -qx "test passed" ||
{ echo "simulation did not pass"; exit 1; }

// File: source/conv_ctrl.sv
`default_nettype none

module conv_ctrl (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 in_valid,
    input  wire                 out_stall,
    output logic                load_en,
    output conv_pkg::ker_idx_t  load_idx,
    output conv_pkg::coord_t    win_y,
    output conv_pkg::coord_t    win_x,
    output conv_pkg::ker_idx_t  ker_sel,
    output logic                issue,
    output logic                advance,
    output logic                busy
);

    conv_pkg::ctrl_state_t state;
    conv_pkg::ctrl_state_t state_nxt;
    conv_pkg::ker_idx_t    beat_cnt;
    logic                  beats_done;
    logic                  last_x;
    logic                  last_y;
    logic                  last_k;
    logic                  last_win;

    assign beats_done = (beat_cnt == conv_pkg::ker_idx_t'(conv_pkg::num_kernels));
    assign last_x     = (win_x == conv_pkg::coord_t'(conv_pkg::win_dim - 1));
    assign last_y     = (win_y == conv_pkg::coord_t'(conv_pkg::win_dim - 1));
    assign last_k     = (ker_sel == conv_pkg::ker_idx_t'(conv_pkg::num_kernels - 1));
    assign last_win   = last_x && last_y && last_k;

    // the stall freezes everything downstream of the address stage
    assign advance  = !out_stall;
    assign issue    = (state == conv_pkg::st_compute);
    assign busy     = (state != conv_pkg::st_idle);
    assign load_idx = beat_cnt;
    assign load_en  = in_valid &&
                      ((state == conv_pkg::st_idle) ||
                       ((state == conv_pkg::st_load) && !beats_done));

    // ----------------------------------------
    // state machine
    // ----------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            conv_pkg::st_idle: begin
                if (in_valid) begin
                    state_nxt = conv_pkg::st_load;
                end
            end
            conv_pkg::st_load: begin
                // one spare cycle after the sixth beat
                if (beats_done) begin
                    state_nxt = conv_pkg::st_compute;
                end
            end
            conv_pkg::st_compute: begin
                if (advance && last_win) begin
                    state_nxt = conv_pkg::st_drain;
                end
            end
            conv_pkg::st_drain: begin
                // last result leaves on this edge
                if (advance) begin
                    state_nxt = conv_pkg::st_idle;
                end
            end
            default: begin
                state_nxt = conv_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= conv_pkg::st_idle;
            beat_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (load_en) begin
                beat_cnt <= beat_cnt + conv_pkg::ker_idx_t'(1);
            end else if (beats_done) begin
                beat_cnt <= '0;
            end
        end
    end

    // ----------------------------------------
    // window walk: x, then y, then kernel
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_x   <= '0;
            win_y   <= '0;
            ker_sel <= '0;
        end else if (issue && advance) begin
            if (!last_x) begin
                win_x <= win_x + conv_pkg::coord_t'(1);
            end else begin
                win_x <= '0;
                if (!last_y) begin
                    win_y <= win_y + conv_pkg::coord_t'(1);
                end else begin
                    win_y   <= '0;
                    ker_sel <= last_k ? '0 : ker_sel + conv_pkg::ker_idx_t'(1);
                end
            end
        end
    end

    a_coord_range: assert property (@(posedge clk) disable iff (!rst_n)
        (win_x < conv_pkg::coord_t'(conv_pkg::win_dim)) &&
        (win_y < conv_pkg::coord_t'(conv_pkg::win_dim)));

    // a new job may only start once the previous one is finished
    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(in_valid) |-> !busy);

endmodule

`default_nettype wire

// File: source/conv_pkg.sv
`default_nettype none

package conv_pkg;

    // ----------------------------------------
    // geometry
    // ----------------------------------------
    localparam int img_dim     = 6;
    // output positions per side for a 2x2 window
    localparam int win_dim     = img_dim - 1;
    localparam int num_kernels = 6;
    localparam int num_taps    = 4;
    localparam int pix_w       = 3;

    // ----------------------------------------
    // data types
    // ----------------------------------------
    typedef logic [pix_w-1:0] pixel_t;
    typedef logic [pix_w-1:0] weight_t;

    // pixel c at bits 3c upward
    typedef logic [img_dim*pix_w-1:0] row_word_t;
    // weights tl, tr, bl, br from bit 0 upward
    typedef logic [num_taps*pix_w-1:0] kernel_word_t;

    // four products of 7*7 peak at 196
    typedef logic [7:0] result_t;
    typedef logic [2:0] coord_t;
    // kernel number, doubles as load beat number
    typedef logic [2:0] ker_idx_t;

    typedef enum logic [1:0] {
        st_idle,
        st_load,
        st_compute,
        st_drain
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: source/conv_top.sv
`default_nettype none

module conv_top (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    in_valid,
    input  conv_pkg::row_word_t    in_row,
    input  conv_pkg::kernel_word_t in_kernel,
    input  wire                    out_stall,
    output logic                   busy,
    output logic                   out_valid,
    output conv_pkg::result_t      out_data
);

    logic               load_en;
    conv_pkg::ker_idx_t load_idx;
    conv_pkg::coord_t   win_y;
    conv_pkg::coord_t   win_x;
    conv_pkg::ker_idx_t ker_sel;
    logic               issue;
    logic               advance;

    // window operands, address stage to mac
    conv_pkg::pixel_t   pix_tl;
    conv_pkg::pixel_t   pix_tr;
    conv_pkg::pixel_t   pix_bl;
    conv_pkg::pixel_t   pix_br;
    conv_pkg::weight_t  w_tl;
    conv_pkg::weight_t  w_tr;
    conv_pkg::weight_t  w_bl;
    conv_pkg::weight_t  w_br;

    conv_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .out_stall (out_stall),
        .load_en   (load_en),
        .load_idx  (load_idx),
        .win_y     (win_y),
        .win_x     (win_x),
        .ker_sel   (ker_sel),
        .issue     (issue),
        .advance   (advance),
        .busy      (busy)
    );

    image_store u_image (
        .clk      (clk),
        .rst_n    (rst_n),
        .load_en  (load_en),
        .load_idx (load_idx),
        .in_row   (in_row),
        .win_y    (win_y),
        .win_x    (win_x),
        .pix_tl   (pix_tl),
        .pix_tr   (pix_tr),
        .pix_bl   (pix_bl),
        .pix_br   (pix_br)
    );

    kernel_store u_kernel (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_en   (load_en),
        .load_idx  (load_idx),
        .in_kernel (in_kernel),
        .ker_sel   (ker_sel),
        .w_tl      (w_tl),
        .w_tr      (w_tr),
        .w_bl      (w_bl),
        .w_br      (w_br)
    );

    mac_stage u_mac (
        .clk       (clk),
        .rst_n     (rst_n),
        .advance   (advance),
        .issue     (issue),
        .pix_tl    (pix_tl),
        .pix_tr    (pix_tr),
        .pix_bl    (pix_bl),
        .pix_br    (pix_br),
        .w_tl      (w_tl),
        .w_tr      (w_tr),
        .w_bl      (w_bl),
        .w_br      (w_br),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

// File: source/image_store.sv
`default_nettype none

module image_store (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   load_en,
    input  conv_pkg::ker_idx_t    load_idx,
    input  conv_pkg::row_word_t   in_row,
    input  conv_pkg::coord_t      win_y,
    input  conv_pkg::coord_t      win_x,
    output conv_pkg::pixel_t      pix_tl,
    output conv_pkg::pixel_t      pix_tr,
    output conv_pkg::pixel_t      pix_bl,
    output conv_pkg::pixel_t      pix_br
);

    // img[row][col]
    conv_pkg::pixel_t img [conv_pkg::img_dim][conv_pkg::img_dim];

    conv_pkg::coord_t x_nxt;
    conv_pkg::coord_t y_nxt;

    // ----------------------------------------
    // row write, one row per load beat
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < conv_pkg::img_dim; r++) begin
                for (int c = 0; c < conv_pkg::img_dim; c++) begin
                    img[r][c] <= '0;
                end
            end
        end else if (load_en) begin
            // unpack, pixel c from bits 3c upward
            for (int c = 0; c < conv_pkg::img_dim; c++) begin
                img[load_idx][c] <= in_row[c*conv_pkg::pix_w +: conv_pkg::pix_w];
            end
        end
    end

    // ----------------------------------------
    // 2x2 window read
    // ----------------------------------------
    // corner stays below win_dim, so +1 is in range
    assign x_nxt = win_x + conv_pkg::coord_t'(1);
    assign y_nxt = win_y + conv_pkg::coord_t'(1);

    assign pix_tl = img[win_y][win_x];
    assign pix_tr = img[win_y][x_nxt];
    assign pix_bl = img[y_nxt][win_x];
    assign pix_br = img[y_nxt][x_nxt];

endmodule

`default_nettype wire

// File: source/kernel_store.sv
`default_nettype none

module kernel_store (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    load_en,
    input  conv_pkg::ker_idx_t     load_idx,
    input  conv_pkg::kernel_word_t in_kernel,
    input  conv_pkg::ker_idx_t     ker_sel,
    output conv_pkg::weight_t      w_tl,
    output conv_pkg::weight_t      w_tr,
    output conv_pkg::weight_t      w_bl,
    output conv_pkg::weight_t      w_br
);

    // ker[kernel][tap], taps in tl, tr, bl, br order
    conv_pkg::weight_t ker [conv_pkg::num_kernels][conv_pkg::num_taps];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < conv_pkg::num_kernels; k++) begin
                for (int w = 0; w < conv_pkg::num_taps; w++) begin
                    ker[k][w] <= '0;
                end
            end
        end else if (load_en) begin
            for (int w = 0; w < conv_pkg::num_taps; w++) begin
                ker[load_idx][w] <= in_kernel[w*conv_pkg::pix_w +: conv_pkg::pix_w];
            end
        end
    end

    // selected kernel, read combinationally
    assign w_tl = ker[ker_sel][0];
    assign w_tr = ker[ker_sel][1];
    assign w_bl = ker[ker_sel][2];
    assign w_br = ker[ker_sel][3];

endmodule

`default_nettype wire

// File: source/mac_stage.sv
`default_nettype none

module mac_stage (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 advance,
    input  wire                 issue,
    input  conv_pkg::pixel_t    pix_tl,
    input  conv_pkg::pixel_t    pix_tr,
    input  conv_pkg::pixel_t    pix_bl,
    input  conv_pkg::pixel_t    pix_br,
    input  conv_pkg::weight_t   w_tl,
    input  conv_pkg::weight_t   w_tr,
    input  conv_pkg::weight_t   w_bl,
    input  conv_pkg::weight_t   w_br,
    output logic                out_valid,
    output conv_pkg::result_t   out_data
);

    conv_pkg::result_t prod_tl;
    conv_pkg::result_t prod_tr;
    conv_pkg::result_t prod_bl;
    conv_pkg::result_t prod_br;
    conv_pkg::result_t sum_top;
    conv_pkg::result_t sum_bot;
    conv_pkg::result_t sum_all;

    // ----------------------------------------
    // products and adder tree
    // ----------------------------------------
    // each product fits in 6 bits, widened before multiplying
    assign prod_tl = conv_pkg::result_t'(pix_tl) * conv_pkg::result_t'(w_tl);
    assign prod_tr = conv_pkg::result_t'(pix_tr) * conv_pkg::result_t'(w_tr);
    assign prod_bl = conv_pkg::result_t'(pix_bl) * conv_pkg::result_t'(w_bl);
    assign prod_br = conv_pkg::result_t'(pix_br) * conv_pkg::result_t'(w_br);

    assign sum_top = prod_tl + prod_tr;
    assign sum_bot = prod_bl + prod_br;
    assign sum_all = sum_top + sum_bot;

    // ----------------------------------------
    // result register
    // ----------------------------------------
    // holds value and flag while the consumer stalls
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else if (advance) begin
            out_valid <= issue;
            out_data  <= sum_all;
        end
    end

    // 4 taps of 7*7 is the ceiling for 3-bit data
    a_result_max: assert property (@(posedge clk) disable iff (!rst_n)
        out_data <= conv_pkg::result_t'(conv_pkg::num_taps *
                    ((1 << conv_pkg::pix_w) - 1) * ((1 << conv_pkg::pix_w) - 1)));

endmodule

`default_nettype wire

// File: testbench/conv_checker.sv
`default_nettype none

module conv_checker (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    in_valid,
    input  conv_pkg::row_word_t    in_row,
    input  conv_pkg::kernel_word_t in_kernel,
    input  wire                    out_stall,
    input  wire                    busy,
    input  wire                    out_valid,
    input  conv_pkg::result_t      out_data,
    input  wire [2:0]              test_id,
    input  wire                    test_end,
    input  wire                    summary,
    output int                     err_total
);

    int img [conv_pkg::img_dim][conv_pkg::img_dim];
    int wt [conv_pkg::num_kernels][conv_pkg::num_taps];
    // expected results of the current job, in delivery order
    int exp_q [$];
    int exp_val;
    int beat_cnt = 0;
    int job_res = 0;
    int test_res = 0;
    int test_err = 0;
    int err_cnt = 0;
    int tests_run = 0;
    int tests_bad = 0;
    logic prev_ok = 1'b0;
    logic prev_stall = 1'b0;
    logic prev_valid = 1'b0;
    conv_pkg::result_t prev_data = '0;

    assign err_total = err_cnt;

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd0: return "reset_state";
            3'd1: return "no_stall";
            3'd2: return "random_stall";
            3'd3: return "all_sevens";
            3'd4: return "zero_kernels";
            default: return "back_to_back";
        endcase
    endfunction

    task automatic note_failure(input string msg);
        $display("%s: %s", test_name(test_id), msg);
        test_err++;
        err_cnt++;
    endtask

    task automatic compare(input string what, input int expected, input int actual);
        if (expected != actual) begin
            $display("ERR %s: %s expected %0d actual %0d",
                     test_name(test_id), what, expected, actual);
            test_err++;
            err_cnt++;
        end
    endtask

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    task automatic build_expected();
        int acc;
        for (int k = 0; k < conv_pkg::num_kernels; k++) begin
            for (int y = 0; y < conv_pkg::win_dim; y++) begin
                for (int x = 0; x < conv_pkg::win_dim; x++) begin
                    acc = 0;
                    for (int i = 0; i < 2; i++) begin
                        for (int j = 0; j < 2; j++) begin
                            acc += img[y+i][x+j] * wt[k][2*i+j];
                        end
                    end
                    exp_q.push_back(acc);
                end
            end
        end
    endtask

    // ----------------------------------------
    // per-edge checks, on values before the edge
    // ----------------------------------------
    always @(posedge clk) begin
        if (rst_n) begin
            if (test_id == 3'd0) begin
                compare("busy after reset", 0, int'(busy));
                compare("out_valid after reset", 0, int'(out_valid));
                compare("out_data after reset", 0, int'(out_data));
            end
            compare("busy", int'(beat_cnt > 0 || exp_q.size() > 0), int'(busy));
            // a stalled edge must leave the output register alone
            if (prev_ok && prev_stall) begin
                compare("out_valid held in stall", int'(prev_valid), int'(out_valid));
                compare("out_data held in stall", int'(prev_data), int'(out_data));
            end
            if (job_res > 0 && exp_q.size() > 0 && !out_valid) begin
                note_failure("out_valid dropped in the middle of a job");
            end
            if (out_valid && !out_stall) begin
                if (exp_q.size() == 0) begin
                    note_failure("a result was delivered with no job pending");
                end else begin
                    exp_val = exp_q.pop_front();
                    compare($sformatf("result k%0d y%0d x%0d", job_res / 25,
                                      (job_res % 25) / 5, job_res % 5),
                            exp_val, int'(out_data));
                    job_res++;
                    test_res++;
                end
            end
            if (in_valid) begin
                for (int c = 0; c < conv_pkg::img_dim; c++) begin
                    img[beat_cnt][c] = int'(in_row[c*conv_pkg::pix_w +: conv_pkg::pix_w]);
                end
                for (int w = 0; w < conv_pkg::num_taps; w++) begin
                    wt[beat_cnt][w] = int'(in_kernel[w*conv_pkg::pix_w +: conv_pkg::pix_w]);
                end
                beat_cnt++;
                if (beat_cnt == conv_pkg::num_kernels) begin
                    if (exp_q.size() != 0) begin
                        note_failure("a new job was loaded before the last one finished");
                    end
                    exp_q.delete();
                    build_expected();
                    beat_cnt = 0;
                    job_res = 0;
                end
            end
            if (test_end) begin
                if (exp_q.size() != 0 || beat_cnt != 0) begin
                    note_failure($sformatf("%0d results missing at the end", exp_q.size()));
                end
                $display("[%s] results=%0d errors=%0d %s", test_name(test_id),
                         test_res, test_err, (test_err == 0) ? "ok" : "FAIL");
                tests_run++;
                if (test_err != 0) begin
                    tests_bad++;
                end
                test_res = 0;
                test_err = 0;
            end
            if (summary) begin
                $display("summary: tests=%0d failing=%0d errors=%0d",
                         tests_run, tests_bad, err_cnt);
            end
        end
        prev_ok    = rst_n;
        prev_stall = out_stall;
        prev_valid = out_valid;
        prev_data  = out_data;
    end

endmodule

`default_nettype wire

// File: testbench/tb_conv.sv
`default_nettype none

module tb_conv;

    localparam logic [31:0] seed      = 32'hf1e5_2c37;
    localparam int          num_jobs  = 7;
    localparam int          stall_pct = 30;
    // load beats, spare cycle, results and a little slack
    localparam int job_cycles = conv_pkg::num_kernels + 4 +
                                conv_pkg::num_kernels * conv_pkg::win_dim * conv_pkg::win_dim;
    localparam int limit_cycles = 4 * (12 + 6 * 2 + num_jobs * job_cycles);

    logic                   clk;
    logic                   rst_n;
    logic                   in_valid;
    conv_pkg::row_word_t    in_row;
    conv_pkg::kernel_word_t in_kernel;
    logic                   out_stall;
    logic                   busy;
    logic                   out_valid;
    conv_pkg::result_t      out_data;
    logic [2:0]             test_id;
    logic                   test_end;
    logic                   summary;
    int                     err_total;
    logic [31:0]            rng;

    conv_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_row    (in_row),
        .in_kernel (in_kernel),
        .out_stall (out_stall),
        .busy      (busy),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    conv_checker u_check (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_row    (in_row),
        .in_kernel (in_kernel),
        .out_stall (out_stall),
        .busy      (busy),
        .out_valid (out_valid),
        .out_data  (out_data),
        .test_id   (test_id),
        .test_end  (test_end),
        .summary   (summary),
        .err_total (err_total)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic drive_stall(input bit stall_en);
        rng = lcg_next(rng);
        out_stall <= stall_en && ((int'(rng[31:16]) % 100) < stall_pct);
    endtask

    // ----------------------------------------
    // one job: six beats, then wait for busy to fall
    // ----------------------------------------
    // mode 0 random, 1 all sevens, 2 random image with zero kernels
    task automatic run_job(input int mode, input bit stall_en);
        for (int b = 0; b < conv_pkg::num_kernels; b++) begin
            @(posedge clk);
            rng = lcg_next(rng);
            in_valid <= 1'b1;
            in_row   <= (mode == 1) ? '1 : rng[31:14];
            rng = lcg_next(rng);
            in_kernel <= (mode == 1) ? '1 : (mode == 2) ? '0 : rng[31:20];
            drive_stall(stall_en);
        end
        @(posedge clk);
        in_valid  <= 1'b0;
        in_row    <= '0;
        in_kernel <= '0;
        drive_stall(stall_en);
        @(negedge clk);
        while (busy) begin
            @(posedge clk);
            drive_stall(stall_en);
            @(negedge clk);
        end
    endtask

    task automatic end_test(input logic [2:0] next_id);
        @(posedge clk);
        out_stall <= 1'b0;
        test_end  <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
        test_id  <= next_id;
    endtask

    initial begin
        rng       = seed;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_row    = '0;
        in_kernel = '0;
        out_stall = 1'b0;
        test_id   = 3'd0;
        test_end  = 1'b0;
        summary   = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);
        end_test(3'd1);
        run_job(0, 1'b0);
        end_test(3'd2);
        run_job(0, 1'b1);
        end_test(3'd3);
        run_job(1, 1'b0);
        end_test(3'd4);
        run_job(2, 1'b0);
        end_test(3'd5);
        // next job starts on the first edge after busy falls
        repeat (3) run_job(0, 1'b0);
        end_test(3'd5);
        @(posedge clk);
        summary <= 1'b1;
        @(posedge clk);
        summary <= 1'b0;
        @(negedge clk);
        if (err_total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", limit_cycles);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire
